/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= wb_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_wb_subsys.sv */
// Directed testbench for the two-master Wishbone subsystem, used as the simulation top module
`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsys
	import wb_pkg::*;
();

	localparam wb_addr_t RAM_BASE  = 32'h0000_0000;
	localparam wb_addr_t RAM_LIMIT = 32'h0000_03FF;
	localparam int       RAM_WORDS = 256;
	localparam int       CLK_HALF  = 5;
	localparam int       DRIVE_DLY = 1;
	// RAM fill plus 18 directed and 64 random transactions
	localparam int       N_TRANS   = RAM_WORDS + 82;
	localparam int       TRANS_CYC = 200;

	logic        clk;
	logic        rstn;
	wb_req_t     m_req [2];
	wb_rsp_t     m_rsp [2];
	wb_data_t    ref_mem [RAM_WORDS];
	logic [31:0] lfsr_state;
	int          last_ram;
	int          done_order [$];

	wb_subsys #(
		.RAM_BASE  (RAM_BASE),
		.RAM_LIMIT (RAM_LIMIT),
		.RAM_WORDS (RAM_WORDS)
	) u_dut (
		.clk      (clk),
		.rstn     (rstn),
		.m0_req_i (m_req[0]),
		.m1_req_i (m_req[1]),
		.m0_rsp_o (m_rsp[0]),
		.m1_rsp_o (m_rsp[1])
	);

	initial begin
		clk = 1'b0;
	end

	always #CLK_HALF clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h", test, exp, act));
		end
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return val;
	endfunction

	function automatic logic in_window(input wb_addr_t adr);
		return (adr >= RAM_BASE) && (adr <= RAM_LIMIT);
	endfunction

	function automatic int word_index(input wb_addr_t adr);
		return int'((adr >> 2) % RAM_WORDS);
	endfunction

	function automatic wb_data_t merge_lanes(input wb_data_t old_w, input wb_data_t new_w,
			input wb_sel_t sel);
		wb_data_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	// One classic cycle on master m held until ACK or ERR before STB drops for a cycle
	task automatic run_cycle(input string test, input int m, input wb_req_t req,
			output wb_rsp_t rsp);
		@(posedge clk);
		#DRIVE_DLY;
		m_req[m] = req;
		do begin
			@(posedge clk);
			#DRIVE_DLY;
		end while (!(m_rsp[m].ack || m_rsp[m].err));
		rsp = m_rsp[m];
		@(posedge clk);
		#DRIVE_DLY;
		m_req[m] = '0;
		done_order.push_back(m);
		// In-window addresses end with ACK and all others with ERR and zero data
		if (in_window(req.adr)) begin
			last_ram = m;
			check_value({test, " ack/err"}, 32'h2, {30'h0, rsp.ack, rsp.err});
		end else begin
			check_value({test, " ack/err"}, 32'h1, {30'h0, rsp.ack, rsp.err});
			check_value({test, " err data"}, 32'h0, rsp.dat_r);
		end
	endtask

	task automatic bus_write(input string test, input int m, input wb_addr_t adr,
			input wb_data_t dat, input wb_sel_t sel);
		wb_req_t req;
		wb_rsp_t rsp;
		req       = '0;
		req.adr   = adr;
		req.dat_w = dat;
		req.sel   = sel;
		req.we    = 1'b1;
		req.cyc   = 1'b1;
		req.stb   = 1'b1;
		run_cycle(test, m, req, rsp);
		if (in_window(adr)) begin
			ref_mem[word_index(adr)] = merge_lanes(ref_mem[word_index(adr)], dat, sel);
		end
	endtask

	task automatic bus_read(input string test, input int m, input wb_addr_t adr);
		wb_req_t req;
		wb_rsp_t rsp;
		req     = '0;
		req.adr = adr;
		req.sel = 4'hf;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		run_cycle(test, m, req, rsp);
		check_value({test, " data"}, in_window(adr) ? ref_mem[word_index(adr)] : '0, rsp.dat_r);
	endtask

	task automatic test_reset();
		for (int m = 0; m < 2; m++) begin
			check_value("test_reset ack/err", 32'h0, {30'h0, m_rsp[m].ack, m_rsp[m].err});
			check_value("test_reset data", 32'h0, m_rsp[m].dat_r);
		end
	endtask

	// Every word gets a pattern of its full byte address
	task automatic fill_ram();
		wb_addr_t adr;
		for (int i = 0; i < RAM_WORDS; i++) begin
			adr = wb_addr_t'(i << 2);
			bus_write("fill_ram", i % 2, adr, (adr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5, 4'hf);
		end
	endtask

	task automatic test_write_read();
		bus_write("test_write_read", 0, 32'h0000_0040, 32'hdead_beef, 4'hf);
		bus_read("test_write_read", 0, 32'h0000_0040);
		bus_write("test_write_read", 1, 32'h0000_0104, 32'h1234_5678, 4'hf);
		bus_read("test_write_read", 1, 32'h0000_0104);
	endtask

	task automatic test_partial();
		bus_write("test_partial", 0, 32'h0000_0080, 32'h1122_3344, 4'hf);
		bus_write("test_partial", 0, 32'h0000_0080, 32'haabb_ccdd, 4'b0101);
		bus_read("test_partial", 1, 32'h0000_0080);
	endtask

	// 0x400 aliases word 0 of the RAM if the access leaked through
	task automatic test_decode_err();
		bus_write("test_decode_err", 0, 32'h0000_0400, 32'hffff_ffff, 4'hf);
		bus_read("test_decode_err", 1, 32'h8000_0000);
		bus_read("test_decode_err", 1, 32'h0000_0000);
	endtask

	task automatic test_contention();
		int first;
		for (int r = 0; r < 2; r++) begin
			// The master after the last RAM grant wins and master 0 when there was none
			first = (last_ram == 0) ? 1 : 0;
			done_order.delete();
			fork
				bus_write("test_contention", 0, 32'h0000_0200, 32'h0c0c_0000 + r, 4'hf);
				bus_write("test_contention", 1, 32'h0000_0300, 32'h1d1d_0000 + r, 4'hf);
			join
			check_value("test_contention order", first, done_order[0]);
			bus_read("test_contention", 0, 32'h0000_0200);
			bus_read("test_contention", 0, 32'h0000_0300);
		end
	endtask

	task automatic test_random();
		int       m;
		wb_addr_t adr;
		wb_data_t dat;
		wb_sel_t  sel;
		for (int i = 0; i < 32; i++) begin
			m   = i % 2;
			adr = lfsr_take(8) << 2;
			dat = lfsr_take(32);
			sel = 4'(lfsr_take(4));
			bus_write("test_random", m, adr, dat, sel);
			bus_read("test_random", 1 - m, adr);
		end
	endtask

	initial begin
		lfsr_state = 32'ha7b6a4db;
		last_ram   = -1;
		rstn       = 1'b0;
		m_req[0]   = '0;
		m_req[1]   = '0;
		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		rstn = 1'b1;
		test_reset();
		fill_ram();
		test_write_read();
		test_partial();
		test_decode_err();
		test_contention();
		test_random();
		$display("TB PASSED");
		$finish;
	end

	initial begin
		#(TRANS_CYC * N_TRANS * 2 * CLK_HALF);
		report_failure("Watchdog timeout, a bus transaction never finished");
	end

endmodule

`default_nettype wire

/* wb_decode_err.sv */
// Decode-error target that answers every cycle routed to it with a single ERR pulse
`timescale 1ns/1ps
`default_nettype none

module wb_decode_err
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic err_q;
	logic access;

	// New strobe only, the ack cycle of the same strobe is skipped
	assign access = req_i.cyc && req_i.stb && !err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= access;
		end
	end

	always_comb begin
		rsp_o.dat_r = '0;
		rsp_o.ack   = 1'b0;
		rsp_o.err   = err_q;
	end

endmodule

`default_nettype wire

/* wb_interconnect_2x1.sv */
// Two-master Wishbone classic interconnect with one shared target and a decode-error responder
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect_2x1
	import wb_pkg::*;
#(
	parameter wb_addr_t RAM_BASE  = 32'h0000_0000,
	parameter wb_addr_t RAM_LIMIT = 32'h0000_03FF
) (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t m0_req_i,
	input  wb_req_t m1_req_i,
	output wb_rsp_t m0_rsp_o,
	output wb_rsp_t m1_rsp_o,
	output wb_req_t s0_req_o,
	input  wb_rsp_t s0_rsp_i
);

	// Target 0 is the RAM, target 1 the decode-error responder
	localparam int N_TGT = 2;
	localparam int MID_W = $clog2(N_MASTERS);

	wb_req_t              m_req [N_MASTERS];
	wb_rsp_t              m_rsp [N_MASTERS];
	tgt_id_t              m_tgt [N_MASTERS];
	logic [N_MASTERS-1:0] m_wait;

	wb_req_t              t_req [N_TGT];
	wb_rsp_t              t_rsp [N_TGT];
	logic [N_MASTERS-1:0] t_req_vec [N_TGT];
	logic [N_TGT-1:0]     t_gnt;
	logic [MID_W-1:0]     t_gnt_id [N_TGT];
	wb_rsp_t              err_rsp;

	assign m_req[0] = m0_req_i;
	assign m_req[1] = m1_req_i;
	assign m0_rsp_o = m_rsp[0];
	assign m1_rsp_o = m_rsp[1];

	assign s0_req_o = t_req[0];
	assign t_rsp[0] = s0_rsp_i;
	assign t_rsp[1] = err_rsp;

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_port
		wb_master_port #(
			.RAM_BASE  (RAM_BASE),
			.RAM_LIMIT (RAM_LIMIT)
		) u_port (
			.clk    (clk),
			.rstn   (rstn),
			.req_i  (m_req[m]),
			.rsp_i  (m_rsp[m]),
			.tgt_o  (m_tgt[m]),
			.wait_o (m_wait[m])
		);
	end

	for (genvar t = 0; t < N_TGT; t++) begin : g_arb
		// A master requests a target while it waits on that target
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_req
			assign t_req_vec[t][m] = m_wait[m] && (m_tgt[m] == tgt_id_t'(t));
		end

		wb_rr_arbiter #(
			.N_REQ (N_MASTERS)
		) u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (t_req_vec[t]),
			.gnt_o    (t_gnt[t]),
			.gnt_id_o (t_gnt_id[t])
		);
	end

	// Granted master's request to each target, all zero when nobody owns it
	always_comb begin
		for (int t = 0; t < N_TGT; t++) begin
			t_req[t] = '0;
			for (int m = 0; m < N_MASTERS; m++) begin
				if (t_gnt[t] && int'(t_gnt_id[t]) == m &&
						m_wait[m] && m_tgt[m] == tgt_id_t'(t)) begin
					t_req[t] = m_req[m];
				end
			end
		end
	end

	// Responses go back only to the owning master
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			m_rsp[m] = '0;
			for (int t = 0; t < N_TGT; t++) begin
				if (m_tgt[m] == tgt_id_t'(t) && t_gnt[t] && int'(t_gnt_id[t]) == m) begin
					m_rsp[m] = t_rsp[t];
				end
			end
		end
	end

	wb_decode_err u_decode_err (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (t_req[1]),
		.rsp_o (err_rsp)
	);

endmodule

`default_nettype wire

/* wb_master_port.sv */
// Per-master address decode and transaction tracker used inside the interconnect
`timescale 1ns/1ps
`default_nettype none

module wb_master_port
	import wb_pkg::*;
#(
	parameter wb_addr_t RAM_BASE  = 32'h0000_0000,
	parameter wb_addr_t RAM_LIMIT = 32'h0000_03FF
) (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	input  wb_rsp_t rsp_i,
	output tgt_id_t tgt_o,
	output logic    wait_o
);

	port_state_t state;
	tgt_id_t     tgt_q;
	tgt_id_t     tgt_dec;

	// Inclusive RAM window, everything else is a decode error
	assign tgt_dec = (req_i.adr >= RAM_BASE && req_i.adr <= RAM_LIMIT) ? TGT_RAM : TGT_ERR;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= PORT_IDLE;
			tgt_q <= TGT_NONE;
		end else begin
			case (state)
				PORT_IDLE: begin
					if (req_i.cyc && req_i.stb) begin
						state <= PORT_WAIT;
						tgt_q <= tgt_dec;
					end
				end
				PORT_WAIT: begin
					// Either response ends the cycle and frees the target
					if (rsp_i.ack || rsp_i.err) begin
						state <= PORT_IDLE;
						tgt_q <= TGT_NONE;
					end
				end
				default: state <= PORT_IDLE;
			endcase
		end
	end

	assign tgt_o  = tgt_q;
	assign wait_o = (state == PORT_WAIT);

	// Response routing must never hand a pulse to an idle master
	a_no_idle_rsp: assert property (@(posedge clk) disable iff (!rstn)
		(state == PORT_IDLE) |-> !(rsp_i.ack || rsp_i.err));

endmodule

`default_nettype wire

/* wb_pkg.sv */
// Shared Wishbone bus types and FSM encodings, imported by the interconnect, targets and testbench
`default_nettype none

package wb_pkg;

	// Number of bus masters sharing the interconnect
	localparam int N_MASTERS = 2;

	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;

	// Master to target request, held steady until ACK or ERR
	typedef struct packed {
		wb_addr_t   adr;
		wb_data_t   dat_w;
		wb_sel_t    sel;
		logic       we;
		logic       cyc;
		logic       stb;
		logic [2:0] cti;
		logic [1:0] bte;
	} wb_req_t;

	// Target to master response, ACK and ERR are one-cycle pulses
	typedef struct packed {
		wb_data_t dat_r;
		logic     ack;
		logic     err;
	} wb_rsp_t;

	// Target selected by a master port, also the index into the target arrays
	typedef enum logic [1:0] {
		TGT_RAM  = 2'd0,
		TGT_ERR  = 2'd1,
		TGT_NONE = 2'd3
	} tgt_id_t;

	typedef enum logic {
		PORT_IDLE,
		PORT_WAIT
	} port_state_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_HELD
	} arb_state_t;

endpackage

`default_nettype wire

/* wb_ram_target.sv */
// Byte-writable single-port RAM behind a Wishbone classic target interface
`timescale 1ns/1ps
`default_nettype none

module wb_ram_target
	import wb_pkg::*;
#(
	parameter int RAM_WORDS = 256
) (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int IDX_W  = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
	localparam int LANES  = $bits(wb_sel_t);

	wb_data_t         mem [RAM_WORDS];
	wb_data_t         rdat_q;
	wb_addr_t         word_adr;
	logic [IDX_W-1:0] idx;
	logic             ack_q;
	logic             access;

	// Byte address to word index wrapping at the RAM depth
	assign word_adr = req_i.adr >> 2;
	assign idx      = IDX_W'(word_adr % wb_addr_t'(RAM_WORDS));

	// Only the first cycle of a strobe does the access
	assign access = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (req_i.we) begin
				for (int b = 0; b < LANES; b++) begin
					if (req_i.sel[b]) begin
						mem[idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
					end
				end
			end else begin
				rdat_q <= mem[idx];
			end
		end
	end

	always_comb begin
		rsp_o.dat_r = rdat_q;
		rsp_o.ack   = ack_q;
		rsp_o.err   = 1'b0;
	end

	// The master keeps its strobe and address steady through the ack cycle
	a_stb_held: assert property (@(posedge clk) disable iff (!rstn)
		access |=> (req_i.cyc && req_i.stb && $stable(req_i.adr) && $stable(req_i.we)));

endmodule

`default_nettype wire

/* wb_rr_arbiter.sv */
// Round-robin arbiter that grants one target to one requester and holds it until the request drops
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter
	import wb_pkg::*;
#(
	parameter int N_REQ = 2
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);

	localparam int ID_W = $clog2(N_REQ);

	arb_state_t       state;
	logic [N_REQ-1:0] last_gnt;
	logic [N_REQ-1:0] above_last;
	logic [N_REQ-1:0] masked_req;
	logic [ID_W-1:0]  pick_id;

	// Index of the lowest set bit
	function automatic logic [ID_W-1:0] first_set(input logic [N_REQ-1:0] vec);
		logic [ID_W-1:0] id;
		id = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (vec[i]) begin
				id = ID_W'(i);
			end
		end
		return id;
	endfunction

	// Requesters strictly above the last granted one
	always_comb begin
		above_last = '0;
		for (int i = 1; i < N_REQ; i++) begin
			above_last[i] = above_last[i-1] | last_gnt[i-1];
		end
	end

	assign masked_req = req_i & above_last;
	assign pick_id    = (|masked_req) ? first_set(masked_req) : first_set(req_i);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state    <= ARB_IDLE;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (|req_i) begin
						state    <= ARB_HELD;
						gnt_id_o <= pick_id;
						last_gnt <= N_REQ'(1) << pick_id;
					end
				end
				ARB_HELD: begin
					if (!req_i[gnt_id_o]) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign gnt_o = (state == ARB_HELD);

	// A new grant always goes to a requester that was asking for the target
	a_gnt_to_req: assert property (@(posedge clk) disable iff (!rstn)
		$rose(gnt_o) |-> |($past(req_i) & (N_REQ'(1) << gnt_id_o)));

endmodule

`default_nettype wire

/* wb_subsys.f */
wb_pkg.sv
wb_rr_arbiter.sv
wb_master_port.sv
wb_decode_err.sv
wb_interconnect_2x1.sv
wb_ram_target.sv
wb_subsys.sv
tb_wb_subsys.sv

/* wb_subsys.sv */
// RTL top level that puts the two-master interconnect in front of the on-chip RAM
`timescale 1ns/1ps
`default_nettype none

module wb_subsys
	import wb_pkg::*;
#(
	parameter wb_addr_t RAM_BASE  = 32'h0000_0000,
	parameter wb_addr_t RAM_LIMIT = 32'h0000_03FF,
	parameter int       RAM_WORDS = 256
) (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t m0_req_i,
	input  wb_req_t m1_req_i,
	output wb_rsp_t m0_rsp_o,
	output wb_rsp_t m1_rsp_o
);

	// Shared target link between interconnect and RAM
	wb_req_t s0_req;
	wb_rsp_t s0_rsp;

	wb_interconnect_2x1 #(
		.RAM_BASE  (RAM_BASE),
		.RAM_LIMIT (RAM_LIMIT)
	) u_interconnect (
		.clk      (clk),
		.rstn     (rstn),
		.m0_req_i (m0_req_i),
		.m1_req_i (m1_req_i),
		.m0_rsp_o (m0_rsp_o),
		.m1_rsp_o (m1_rsp_o),
		.s0_req_o (s0_req),
		.s0_rsp_i (s0_rsp)
	);

	wb_ram_target #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s0_req),
		.rsp_o (s0_rsp)
	);

endmodule

`default_nettype wire
